//--- Makefile
VERILATOR ?= verilator
FLAGS ?= --timing --assert
TOP ?= decode_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
+incdir+source
source/decode_pkg.sv
source/instr_decoder.sv
source/hazard_unit.sv
source/decode_stage.sv
source/register_file.sv
source/decode_top.sv
test/clock_gen.sv
test/decode_tb.sv

//--- source/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// width of data words and of raw instructions.
`define DEC_XLEN 32

// integer register count and the index width that addresses it.
`define DEC_NREGS 32
`define DEC_RADDR_W 5

`endif

//--- source/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

  typedef logic [`DEC_XLEN-1:0] xlen_t;
  typedef logic [`DEC_XLEN-1:0] instr_t;
  typedef logic [`DEC_RADDR_W-1:0] reg_addr_t;
  typedef logic [3:0] alu_op_t;
  typedef logic [2:0] lsu_op_t;
  typedef logic [3:0] cause_t;

  // machine-mode exception causes raised at decode.
  localparam cause_t cause_illegal = 4'd2;
  localparam cause_t cause_breakpoint = 4'd3;
  localparam cause_t cause_ecall_m = 4'd11;

  localparam alu_op_t alu_add = 4'd0;
  localparam alu_op_t alu_sub = 4'd1;
  localparam alu_op_t alu_sll = 4'd2;
  localparam alu_op_t alu_slt = 4'd3;
  localparam alu_op_t alu_sltu = 4'd4;
  localparam alu_op_t alu_xor = 4'd5;
  localparam alu_op_t alu_srl = 4'd6;
  localparam alu_op_t alu_sra = 4'd7;
  localparam alu_op_t alu_or = 4'd8;
  localparam alu_op_t alu_and = 4'd9;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic auipc;
    logic lui;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic csreg;
    logic cwren;
    logic division;
    logic mult;
    logic fence;
    logic ecall;
    logic ebreak;
    logic mret;
    logic valid;
    logic exception;
  } op_flags_t;

  typedef struct packed {
    xlen_t pc0;
    instr_t instr0;
    xlen_t pc1;
    instr_t instr1;
    logic swap;
    logic pred_taken;
  } fetch_bundle_t;

  typedef struct packed {
    xlen_t pc;
    instr_t instr;
    xlen_t imm;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    op_flags_t flags;
    alu_op_t alu_op;
    lsu_op_t lsu_op;
    cause_t ecause;
  } slot_t;

  typedef struct packed {
    logic ex_load0;
    reg_addr_t ex_waddr0;
    logic ex_load1;
    reg_addr_t ex_waddr1;
    logic ex_cwren;
    logic mem_cwren;
    logic ex_division;
    logic ex_fence;
  } pipe_state_t;

  typedef struct packed {
    logic rden;
    reg_addr_t raddr;
  } read_req_t;

  typedef struct packed {
    logic wren;
    reg_addr_t waddr;
    xlen_t wdata;
  } wb_t;

  typedef struct packed {
    slot_t slot0;
    slot_t slot1;
    logic swap;
    logic stall;
  } issue_t;

endpackage

//--- source/decode_stage.sv
module decode_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  decode_pkg::fetch_bundle_t fetch,
  input  decode_pkg::pipe_state_t   pipe,
  input  logic                      hold,
  input  logic                      flush,
  output decode_pkg::read_req_t     read_req [4],
  output decode_pkg::issue_t        issue
);
  import decode_pkg::*;

  op_flags_t flags0;
  op_flags_t flags1;
  xlen_t imm0;
  xlen_t imm1;
  alu_op_t alu_op0;
  alu_op_t alu_op1;
  lsu_op_t lsu_op0;
  lsu_op_t lsu_op1;
  slot_t slot0;
  slot_t slot1;
  logic kill1;
  logic hazard;
  logic bubble;
  issue_t issue_d;
  issue_t issue_q;

  instr_decoder #(
    .full_set(1'b1)
  ) decoder0_inst (
    .instr(fetch.instr0),
    .slot_flags(flags0),
    .imm(imm0),
    .alu_op(alu_op0),
    .lsu_op(lsu_op0)
  );

  instr_decoder #(
    .full_set(1'b0)
  ) decoder1_inst (
    .instr(fetch.instr1),
    .slot_flags(flags1),
    .imm(imm1),
    .alu_op(alu_op1),
    .lsu_op(lsu_op1)
  );

  // slot 1 sits behind a taken branch unless the fetch order is swapped.
  assign kill1 = !fetch.swap && fetch.pred_taken;

  always_comb begin
    slot0.pc = fetch.pc0;
    slot0.instr = fetch.instr0;
    slot0.imm = imm0;
    slot0.waddr = fetch.instr0[11:7];
    slot0.raddr1 = fetch.instr0[19:15];
    slot0.raddr2 = fetch.instr0[24:20];
    slot0.flags = flags0;
    slot0.alu_op = alu_op0;
    slot0.lsu_op = lsu_op0;
    slot0.ecause = '0;
    if (!flags0.valid) begin
      slot0.flags.exception = 1'b1;
      slot0.ecause = cause_illegal;
    end else if (flags0.ebreak) begin
      slot0.flags.exception = 1'b1;
      slot0.ecause = cause_breakpoint;
    end else if (flags0.ecall) begin
      slot0.flags.exception = 1'b1;
      slot0.ecause = cause_ecall_m;
    end

    slot1.pc = fetch.pc1;
    slot1.instr = fetch.instr1;
    slot1.imm = imm1;
    slot1.waddr = fetch.instr1[11:7];
    slot1.raddr1 = fetch.instr1[19:15];
    slot1.raddr2 = fetch.instr1[24:20];
    slot1.flags = flags1;
    slot1.alu_op = alu_op1;
    slot1.lsu_op = lsu_op1;
    slot1.ecause = '0;
    if (!flags1.valid) begin
      slot1.flags.exception = 1'b1;
      slot1.ecause = cause_illegal;
    end
    if (kill1) begin
      slot1.flags = '0;
      slot1.ecause = '0;
    end
  end

  hazard_unit hazard_inst (
    .slot0(slot0),
    .slot1(slot1),
    .pipe(pipe),
    .stall(hazard)
  );

  assign read_req[0] = '{rden: slot0.flags.rden1, raddr: slot0.raddr1};
  assign read_req[1] = '{rden: slot0.flags.rden2, raddr: slot0.raddr2};
  assign read_req[2] = '{rden: slot1.flags.rden1, raddr: slot1.raddr1};
  assign read_req[3] = '{rden: slot1.flags.rden2, raddr: slot1.raddr2};

  assign bubble = hazard | pipe.ex_fence | flush;

  always_comb begin
    issue_d.slot0 = slot0;
    issue_d.slot1 = slot1;
    issue_d.swap = fetch.swap;
    issue_d.stall = hazard && !flush;
    if (bubble) begin
      issue_d.slot0.flags = '0;
      issue_d.slot1.flags = '0;
    end
  end

  // a flush still loads its bubble while downstream holds.
  always_ff @(posedge clock) begin
    if (!reset) begin
      issue_q <= '0;
    end else if (!hold || flush) begin
      issue_q <= issue_d;
    end
  end

  assign issue = issue_q;

  flush_drops_stall: assert property (@(posedge clock) disable iff (!reset)
    flush |=> !issue.stall)
    else $error("issue.stall high in the cycle after a flush");

endmodule

//--- source/decode_top.sv
module decode_top (
  input  logic                      clock,
  input  logic                      reset,
  input  decode_pkg::fetch_bundle_t fetch,
  input  decode_pkg::pipe_state_t   pipe,
  input  logic                      hold,
  input  logic                      flush,
  input  decode_pkg::wb_t           writeback,
  output decode_pkg::issue_t        issue,
  output decode_pkg::xlen_t         operands [4]
);
  import decode_pkg::*;

  read_req_t read_req [4];

  decode_stage decode_stage_inst (
    .clock(clock),
    .reset(reset),
    .fetch(fetch),
    .pipe(pipe),
    .hold(hold),
    .flush(flush),
    .read_req(read_req),
    .issue(issue)
  );

  // operands come out on the same cycle as the registered issue bundle.
  register_file register_file_inst (
    .clock(clock),
    .reset(reset),
    .read_req(read_req),
    .hold(hold),
    .writeback(writeback),
    .rdata(operands)
  );

endmodule

//--- source/hazard_unit.sv
module hazard_unit (
  input  decode_pkg::slot_t       slot0,
  input  decode_pkg::slot_t       slot1,
  input  decode_pkg::pipe_state_t pipe,
  output logic                    stall
);
  import decode_pkg::*;

  logic load_hit0;
  logic load_hit1;
  logic serialize;

  function automatic logic reads_reg(slot_t s, reg_addr_t a);
    return (s.flags.rden1 && s.raddr1 == a) || (s.flags.rden2 && s.raddr2 == a);
  endfunction

  // a load in execute has no data to forward until the memory stage.
  assign load_hit0 = pipe.ex_load0 && (pipe.ex_waddr0 != '0) &&
                     (reads_reg(slot0, pipe.ex_waddr0) || reads_reg(slot1, pipe.ex_waddr0));
  assign load_hit1 = pipe.ex_load1 && (pipe.ex_waddr1 != '0) &&
                     (reads_reg(slot0, pipe.ex_waddr1) || reads_reg(slot1, pipe.ex_waddr1));

  // csr writes and the iterative divider hold decode until they retire.
  assign serialize = pipe.ex_cwren | pipe.mem_cwren | pipe.ex_division;

  assign stall = serialize | load_hit0 | load_hit1;

endmodule

//--- source/instr_decoder.sv
module instr_decoder #(
  parameter bit full_set = 1'b1
) (
  input  decode_pkg::instr_t    instr,
  output decode_pkg::op_flags_t slot_flags,
  output decode_pkg::xlen_t     imm,
  output decode_pkg::alu_op_t   alu_op,
  output decode_pkg::lsu_op_t   lsu_op
);
  import decode_pkg::*;

  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jalr = 7'b1100111;
  localparam logic [6:0] opc_jal = 7'b1101111;
  localparam logic [6:0] opc_system = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  logic basic;

  // shared funct3 mapping of the register and immediate ALU forms.
  function automatic alu_op_t alu_map(logic [2:0] f3, logic alt);
    case (f3)
      3'b000: return alt ? alu_sub : alu_add;
      3'b001: return alu_sll;
      3'b010: return alu_slt;
      3'b011: return alu_sltu;
      3'b100: return alu_xor;
      3'b101: return alt ? alu_sra : alu_srl;
      3'b110: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    slot_flags = '0;
    imm = '0;
    alu_op = alu_add;
    lsu_op = funct3;
    basic = 1'b0;
    case (opcode)
      opc_lui: begin
        slot_flags.wren = 1'b1;
        slot_flags.lui = 1'b1;
        slot_flags.valid = 1'b1;
        imm = imm_u;
        basic = 1'b1;
      end
      opc_auipc: begin
        slot_flags.wren = 1'b1;
        slot_flags.auipc = 1'b1;
        slot_flags.valid = 1'b1;
        imm = imm_u;
        basic = 1'b1;
      end
      opc_jal: begin
        slot_flags.wren = 1'b1;
        slot_flags.jal = 1'b1;
        slot_flags.valid = 1'b1;
        imm = imm_j;
      end
      opc_jalr: begin
        slot_flags.wren = 1'b1;
        slot_flags.rden1 = 1'b1;
        slot_flags.jalr = 1'b1;
        slot_flags.valid = (funct3 == 3'b000);
        imm = imm_i;
      end
      opc_branch: begin
        slot_flags.rden1 = 1'b1;
        slot_flags.rden2 = 1'b1;
        slot_flags.branch = 1'b1;
        slot_flags.valid = (funct3[2:1] != 2'b01);
        imm = imm_b;
        case (funct3[2:1])
          2'b10: alu_op = alu_slt;
          2'b11: alu_op = alu_sltu;
          default: alu_op = alu_sub;
        endcase
      end
      opc_load: begin
        slot_flags.wren = 1'b1;
        slot_flags.rden1 = 1'b1;
        slot_flags.load = 1'b1;
        slot_flags.valid = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
        imm = imm_i;
        basic = 1'b1;
      end
      opc_store: begin
        slot_flags.rden1 = 1'b1;
        slot_flags.rden2 = 1'b1;
        slot_flags.store = 1'b1;
        slot_flags.valid = !funct3[2] && (funct3 != 3'b011);
        imm = imm_s;
        basic = 1'b1;
      end
      opc_op_imm: begin
        slot_flags.wren = 1'b1;
        slot_flags.rden1 = 1'b1;
        imm = imm_i;
        basic = 1'b1;
        alu_op = alu_map(funct3, (funct3 == 3'b101) && funct7[5]);
        case (funct3)
          3'b001: slot_flags.valid = (funct7 == 7'b0000000);
          3'b101: slot_flags.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: slot_flags.valid = 1'b1;
        endcase
      end
      opc_op: begin
        slot_flags.wren = 1'b1;
        slot_flags.rden1 = 1'b1;
        slot_flags.rden2 = 1'b1;
        if (funct7 == 7'b0000001) begin
          // the multiply/divide kind stays in funct3 for the execute units.
          slot_flags.mult = !funct3[2];
          slot_flags.division = funct3[2];
          slot_flags.valid = 1'b1;
        end else begin
          basic = 1'b1;
          alu_op = alu_map(funct3, funct7[5]);
          slot_flags.valid = (funct7 == 7'b0000000) ||
                             (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        end
      end
      opc_misc_mem: begin
        slot_flags.fence = 1'b1;
        slot_flags.valid = (funct3[2:1] == 2'b00);
      end
      opc_system: begin
        if (funct3 == 3'b000) begin
          slot_flags.ecall = (instr == 32'h00000073);
          slot_flags.ebreak = (instr == 32'h00100073);
          slot_flags.mret = (instr == 32'h30200073);
          slot_flags.valid = slot_flags.ecall | slot_flags.ebreak | slot_flags.mret;
        end else begin
          // csr read-set and read-clear with a zero source leave the csr untouched.
          slot_flags.csreg = 1'b1;
          slot_flags.wren = 1'b1;
          slot_flags.rden1 = !funct3[2];
          slot_flags.cwren = (funct3[1:0] == 2'b01) || (instr[19:15] != 5'd0);
          slot_flags.valid = (funct3 != 3'b100);
          imm = xlen_t'(instr[19:15]);
        end
      end
      default: begin
        slot_flags = '0;
      end
    endcase
    // an invalid instruction must not touch the register file.
    if ((!full_set && !basic) || !slot_flags.valid) begin
      slot_flags = '0;
    end
  end

  always_comb begin
    if (!$isunknown(instr)) begin
      assert ($onehot0({slot_flags.load, slot_flags.store, slot_flags.branch, slot_flags.jal}))
        else $error("decoder raised more than one control transfer or memory flag");
    end
  end

endmodule

//--- source/register_file.sv
`include "decode_cfg.svh"

module register_file (
  input  logic                  clock,
  input  logic                  reset,
  input  decode_pkg::read_req_t read_req [4],
  input  logic                  hold,
  input  decode_pkg::wb_t       writeback,
  output decode_pkg::xlen_t     rdata [4]
);
  import decode_pkg::*;

  xlen_t regs [`DEC_NREGS];

  // x0 is never written, and reads of it are forced to zero below.
  always_ff @(posedge clock) begin
    if (writeback.wren && writeback.waddr != '0) begin
      regs[writeback.waddr] <= writeback.wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 4; i++) begin
        rdata[i] <= '0;
      end
    end else if (!hold) begin
      for (int i = 0; i < 4; i++) begin
        if (!read_req[i].rden || read_req[i].raddr == '0) begin
          rdata[i] <= '0;
        end else if (writeback.wren && writeback.waddr == read_req[i].raddr) begin
          // a write landing on this edge is seen by the read of the same edge.
          rdata[i] <= writeback.wdata;
        end else begin
          rdata[i] <= regs[read_req[i].raddr];
        end
      end
    end
  end

endmodule

//--- test/clock_gen.sv
module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // reset is held low across the first two rising edges.
  initial begin
    reset = 1'b0;
    repeat (2) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

//--- test/decode_tb.sv
`include "decode_cfg.svh"

module decode_tb;
  import decode_pkg::*;

  localparam int clock_period = 8;
  localparam int preload_count = `DEC_NREGS - 1;

  typedef struct packed {
    fetch_bundle_t fetch;
    pipe_state_t pipe;
    logic hold;
    logic flush;
    wb_t wb;
    op_flags_t flags0;
    xlen_t imm0;
    cause_t cause0;
    reg_addr_t waddr0;
    op_flags_t flags1;
    xlen_t imm1;
    cause_t cause1;
    reg_addr_t waddr1;
    logic stall;
    logic [3:0][4:0] oregs;
  } entry_t;

  // expected op flags of each instruction class, from the RV32I rules.
  localparam op_flags_t f_none = '0;
  localparam op_flags_t f_alui = '{wren: 1'b1, rden1: 1'b1, valid: 1'b1, default: 1'b0};
  localparam op_flags_t f_alu = '{wren: 1'b1, rden1: 1'b1, rden2: 1'b1, valid: 1'b1,
                                  default: 1'b0};
  localparam op_flags_t f_lui = '{wren: 1'b1, lui: 1'b1, valid: 1'b1, default: 1'b0};
  localparam op_flags_t f_load = '{wren: 1'b1, rden1: 1'b1, load: 1'b1, valid: 1'b1,
                                   default: 1'b0};
  localparam op_flags_t f_store = '{rden1: 1'b1, rden2: 1'b1, store: 1'b1, valid: 1'b1,
                                    default: 1'b0};
  localparam op_flags_t f_illegal = '{exception: 1'b1, default: 1'b0};
  localparam op_flags_t f_ebreak = '{ebreak: 1'b1, valid: 1'b1, exception: 1'b1,
                                     default: 1'b0};
  localparam op_flags_t f_ecall = '{ecall: 1'b1, valid: 1'b1, exception: 1'b1, default: 1'b0};

  localparam pipe_state_t p_none = '0;
  localparam pipe_state_t p_load3 = '{ex_load0: 1'b1, ex_waddr0: 5'd3, default: '0};
  localparam pipe_state_t p_load_x0 = '{ex_load1: 1'b1, default: '0};
  localparam pipe_state_t p_cwren = '{ex_cwren: 1'b1, default: '0};
  localparam pipe_state_t p_div = '{ex_division: 1'b1, default: '0};

  localparam wb_t wb_none = '0;
  localparam wb_t wb_x20 = '{wren: 1'b1, waddr: 5'd20, wdata: 32'hdead_beef};
  localparam cause_t c_none = 4'd0;

  logic clock;
  logic reset;
  fetch_bundle_t fetch;
  pipe_state_t pipe;
  logic hold;
  logic flush;
  wb_t writeback;
  issue_t issue;
  xlen_t operands [4];

  entry_t rows [$];
  entry_t cur;
  xlen_t model [`DEC_NREGS];
  xlen_t exp_ops [4];
  logic exp_swap;
  logic [31:0] rng_state;
  string context_name;
  int error_count;
  int entry_errors;
  int failed_entries;

  clock_gen clock_gen_inst (
    .clock(clock),
    .reset(reset)
  );

  decode_top decode_top_inst (
    .clock(clock),
    .reset(reset),
    .fetch(fetch),
    .pipe(pipe),
    .hold(hold),
    .flush(flush),
    .writeback(writeback),
    .issue(issue),
    .operands(operands)
  );

  function automatic xlen_t next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic instr_t enc_i(logic [6:0] opc, reg_addr_t rd, logic [2:0] f3,
                                   reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_s(reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3,
                                   logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t enc_r(logic [6:0] f7, reg_addr_t rd, logic [2:0] f3,
                                   reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t enc_u(logic [6:0] opc, reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic instr_t enc_b(reg_addr_t rs1, reg_addr_t rs2, logic [2:0] f3,
                                   logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic fetch_bundle_t bundle(instr_t i0, instr_t i1, logic swap, logic pred);
    fetch_bundle_t f;
    f.pc0 = 32'h0000_0100;
    f.instr0 = i0;
    f.pc1 = 32'h0000_0104;
    f.instr1 = i1;
    f.swap = swap;
    f.pred_taken = pred;
    return f;
  endfunction

  // port order is slot 0 rs1, slot 0 rs2, slot 1 rs1, slot 1 rs2.
  function automatic logic [3:0][4:0] regs4(reg_addr_t r0, reg_addr_t r1, reg_addr_t r2,
                                            reg_addr_t r3);
    return {r3, r2, r1, r0};
  endfunction

  task automatic add_row(input fetch_bundle_t f, input pipe_state_t p, input logic hd,
                         input logic fl, input wb_t wb, input op_flags_t fl0, input xlen_t im0,
                         input cause_t c0, input reg_addr_t w0, input op_flags_t fl1,
                         input xlen_t im1, input cause_t c1, input reg_addr_t w1,
                         input logic st, input logic [3:0][4:0] oregs);
    entry_t e;
    e = '{fetch: f, pipe: p, hold: hd, flush: fl, wb: wb, flags0: fl0, imm0: im0, cause0: c0,
          waddr0: w0, flags1: fl1, imm1: im1, cause1: c1, waddr1: w1, stall: st, oregs: oregs};
    rows.push_back(e);
  endtask

  // a held entry expects the previous issue and operands again.
  task automatic add_hold_row(input fetch_bundle_t f);
    entry_t e;
    e = rows[rows.size() - 1];
    e.fetch = f;
    e.pipe = p_none;
    e.hold = 1'b1;
    e.flush = 1'b0;
    e.wb = wb_none;
    rows.push_back(e);
  endtask

  task automatic build_table();
    instr_t i_addi;
    instr_t i_lui;
    instr_t i_lw;
    instr_t i_sw;
    instr_t i_add;
    instr_t i_addi_max;
    instr_t i_beq;
    instr_t i_add_b;
    instr_t i_add_wf;
    instr_t i_addi_wf;
    i_addi = enc_i(7'b0010011, 5'd5, 3'b000, 5'd3, 12'hffb);
    i_lui = enc_u(7'b0110111, 5'd6, 20'h12345);
    i_lw = enc_i(7'b0000011, 5'd7, 3'b010, 5'd4, 12'd16);
    i_sw = enc_s(5'd9, 5'd10, 3'b010, 12'hff8);
    i_add = enc_r(7'd0, 5'd8, 3'b000, 5'd0, 5'd2);
    i_addi_max = enc_i(7'b0010011, 5'd11, 3'b000, 5'd12, 12'h7ff);
    i_beq = enc_b(5'd1, 5'd2, 3'b000, 13'd8);
    i_add_b = enc_r(7'd0, 5'd13, 3'b000, 5'd14, 5'd15);
    i_add_wf = enc_r(7'd0, 5'd21, 3'b000, 5'd20, 5'd20);
    i_addi_wf = enc_i(7'b0010011, 5'd22, 3'b000, 5'd20, 12'd1);

    add_row(bundle(i_addi, i_lui, 1'b0, 1'b0), p_none, 1'b0, 1'b0, wb_none,
            f_alui, 32'hffff_fffb, c_none, 5'd5, f_lui, 32'h1234_5000, c_none, 5'd6,
            1'b0, regs4(5'd3, 5'd0, 5'd0, 5'd0));
    add_row(bundle(i_lw, i_sw, 1'b0, 1'b0), p_none, 1'b0, 1'b0, wb_none,
            f_load, 32'd16, c_none, 5'd7, f_store, 32'hffff_fff8, c_none, 5'd0,
            1'b0, regs4(5'd4, 5'd0, 5'd10, 5'd9));
    add_row(bundle(i_add, i_addi_max, 1'b0, 1'b0), p_none, 1'b0, 1'b0, wb_none,
            f_alu, 32'd0, c_none, 5'd8, f_alui, 32'h0000_07ff, c_none, 5'd11,
            1'b0, regs4(5'd0, 5'd2, 5'd12, 5'd0));
    add_row(bundle(32'hffff_ffff, i_addi, 1'b0, 1'b0), p_none, 1'b0, 1'b0, wb_none,
            f_illegal, 32'd0, cause_illegal, 5'd0, f_alui, 32'hffff_fffb, c_none, 5'd5,
            1'b0, regs4(5'd0, 5'd0, 5'd3, 5'd0));
    add_row(bundle(32'h0010_0073, i_lui, 1'b0, 1'b0), p_none, 1'b0, 1'b0, wb_none,
            f_ebreak, 32'd0, cause_breakpoint, 5'd0, f_lui, 32'h1234_5000, c_none, 5'd6,
            1'b0, regs4(5'd0, 5'd0, 5'd0, 5'd0));
    add_row(bundle(32'h0000_0073, i_beq, 1'b0, 1'b0), p_none, 1'b0, 1'b0, wb_none,
            f_ecall, 32'd0, cause_ecall_m, 5'd0, f_illegal, 32'd8, cause_illegal, 5'd0,
            1'b0, regs4(5'd0, 5'd0, 5'd0, 5'd0));
    // a stall issues a bubble but the reads still happen.
    add_row(bundle(i_addi, i_lui, 1'b0, 1'b0), p_load3, 1'b0, 1'b0, wb_none,
            f_none, 32'hffff_fffb, c_none, 5'd0, f_none, 32'h1234_5000, c_none, 5'd0,
            1'b1, regs4(5'd3, 5'd0, 5'd0, 5'd0));
    add_row(bundle(i_add, i_addi_max, 1'b0, 1'b0), p_load_x0, 1'b0, 1'b0, wb_none,
            f_alu, 32'd0, c_none, 5'd8, f_alui, 32'h0000_07ff, c_none, 5'd11,
            1'b0, regs4(5'd0, 5'd2, 5'd12, 5'd0));
    add_row(bundle(i_addi, i_lui, 1'b0, 1'b0), p_cwren, 1'b0, 1'b0, wb_none,
            f_none, 32'hffff_fffb, c_none, 5'd0, f_none, 32'h1234_5000, c_none, 5'd0,
            1'b1, regs4(5'd3, 5'd0, 5'd0, 5'd0));
    add_row(bundle(i_lw, i_sw, 1'b0, 1'b0), p_div, 1'b0, 1'b0, wb_none,
            f_none, 32'd16, c_none, 5'd0, f_none, 32'hffff_fff8, c_none, 5'd0,
            1'b1, regs4(5'd4, 5'd0, 5'd10, 5'd9));
    add_row(bundle(i_addi, i_lui, 1'b0, 1'b0), p_none, 1'b0, 1'b0, wb_none,
            f_alui, 32'hffff_fffb, c_none, 5'd5, f_lui, 32'h1234_5000, c_none, 5'd6,
            1'b0, regs4(5'd3, 5'd0, 5'd0, 5'd0));
    add_hold_row(bundle(i_lw, i_sw, 1'b0, 1'b0));
    add_row(bundle(i_lw, i_sw, 1'b0, 1'b0), p_cwren, 1'b0, 1'b1, wb_none,
            f_none, 32'd16, c_none, 5'd0, f_none, 32'hffff_fff8, c_none, 5'd0,
            1'b0, regs4(5'd4, 5'd0, 5'd10, 5'd9));
    add_row(bundle(i_addi, i_add_b, 1'b0, 1'b1), p_none, 1'b0, 1'b0, wb_none,
            f_alui, 32'hffff_fffb, c_none, 5'd5, f_none, 32'd0, c_none, 5'd0,
            1'b0, regs4(5'd3, 5'd0, 5'd0, 5'd0));
    add_row(bundle(i_addi, i_add_b, 1'b1, 1'b1), p_none, 1'b0, 1'b0, wb_none,
            f_alui, 32'hffff_fffb, c_none, 5'd5, f_alu, 32'd0, c_none, 5'd13,
            1'b0, regs4(5'd3, 5'd0, 5'd14, 5'd15));
    add_row(bundle(i_add_wf, i_addi_wf, 1'b0, 1'b0), p_none, 1'b0, 1'b0, wb_x20,
            f_alu, 32'd0, c_none, 5'd21, f_alui, 32'd1, c_none, 5'd22,
            1'b0, regs4(5'd20, 5'd20, 5'd20, 5'd0));
  endtask

  task automatic report_mismatch(input string field, input xlen_t expected, input xlen_t actual);
    $display("mismatch at time %0t: %s %s expected %h got %h",
             $time, context_name, field, expected, actual);
    error_count++;
    entry_errors++;
  endtask

  // the write of an entry lands on the same edge as its read, so the model moves first.
  task automatic apply_entry();
    fetch = cur.fetch;
    pipe = cur.pipe;
    hold = cur.hold;
    flush = cur.flush;
    writeback = cur.wb;
    if (cur.wb.wren && cur.wb.waddr != '0) begin
      model[cur.wb.waddr] = cur.wb.wdata;
    end
  endtask

  task automatic check_entry();
    if (!cur.hold) begin
      for (int k = 0; k < 4; k++) begin
        exp_ops[k] = (cur.oregs[k] == '0) ? '0 : model[cur.oregs[k]];
      end
      exp_swap = cur.fetch.swap;
    end
    if (issue.slot0.flags !== cur.flags0)
      report_mismatch("slot0 flags", xlen_t'(cur.flags0), xlen_t'(issue.slot0.flags));
    if (issue.slot1.flags !== cur.flags1)
      report_mismatch("slot1 flags", xlen_t'(cur.flags1), xlen_t'(issue.slot1.flags));
    if (issue.slot0.imm !== cur.imm0)
      report_mismatch("slot0 imm", cur.imm0, issue.slot0.imm);
    if (issue.slot1.imm !== cur.imm1)
      report_mismatch("slot1 imm", cur.imm1, issue.slot1.imm);
    if (issue.slot0.ecause !== cur.cause0)
      report_mismatch("slot0 cause", xlen_t'(cur.cause0), xlen_t'(issue.slot0.ecause));
    if (issue.slot1.ecause !== cur.cause1)
      report_mismatch("slot1 cause", xlen_t'(cur.cause1), xlen_t'(issue.slot1.ecause));
    if (cur.flags0.wren && issue.slot0.waddr !== cur.waddr0)
      report_mismatch("slot0 waddr", xlen_t'(cur.waddr0), xlen_t'(issue.slot0.waddr));
    if (cur.flags1.wren && issue.slot1.waddr !== cur.waddr1)
      report_mismatch("slot1 waddr", xlen_t'(cur.waddr1), xlen_t'(issue.slot1.waddr));
    if (cur.flags0.rden1 && issue.slot0.raddr1 !== cur.oregs[0])
      report_mismatch("slot0 raddr1", xlen_t'(cur.oregs[0]), xlen_t'(issue.slot0.raddr1));
    if (cur.flags0.rden2 && issue.slot0.raddr2 !== cur.oregs[1])
      report_mismatch("slot0 raddr2", xlen_t'(cur.oregs[1]), xlen_t'(issue.slot0.raddr2));
    if (cur.flags1.rden1 && issue.slot1.raddr1 !== cur.oregs[2])
      report_mismatch("slot1 raddr1", xlen_t'(cur.oregs[2]), xlen_t'(issue.slot1.raddr1));
    if (cur.flags1.rden2 && issue.slot1.raddr2 !== cur.oregs[3])
      report_mismatch("slot1 raddr2", xlen_t'(cur.oregs[3]), xlen_t'(issue.slot1.raddr2));
    if (issue.swap !== exp_swap)
      report_mismatch("swap", xlen_t'(exp_swap), xlen_t'(issue.swap));
    if (issue.stall !== cur.stall)
      report_mismatch("stall", xlen_t'(cur.stall), xlen_t'(issue.stall));
    for (int k = 0; k < 4; k++) begin
      if (operands[k] !== exp_ops[k])
        report_mismatch($sformatf("operand %0d", k), exp_ops[k], operands[k]);
    end
  endtask

  initial begin
    fetch = '0;
    pipe = '0;
    hold = 1'b0;
    flush = 1'b0;
    writeback = '0;
    rng_state = 32'd95789;
    error_count = 0;
    entry_errors = 0;
    failed_entries = 0;
    model[0] = '0;
    build_table();

    @(posedge reset);
    context_name = "reset";
    if (issue.slot0.flags !== f_none)
      report_mismatch("slot0 flags", '0, xlen_t'(issue.slot0.flags));
    if (issue.slot1.flags !== f_none)
      report_mismatch("slot1 flags", '0, xlen_t'(issue.slot1.flags));
    if (issue.stall !== 1'b0)
      report_mismatch("stall", '0, xlen_t'(issue.stall));

    for (int r = 1; r <= preload_count; r++) begin
      @(posedge clock);
      #1;
      model[r] = next_random();
      writeback = '{wren: 1'b1, waddr: reg_addr_t'(r), wdata: model[r]};
    end
    @(posedge clock);
    #1;

    for (int i = 0; i < rows.size(); i++) begin
      cur = rows[i];
      context_name = $sformatf("entry %0d", i);
      entry_errors = 0;
      apply_entry();
      @(posedge clock);
      #1;
      check_entry();
      if (entry_errors != 0) begin
        failed_entries++;
      end
      $display("entry %0d done with %0d mismatches", i, entry_errors);
    end

    $display("entries %0d, entries with errors %0d, mismatches %0d",
             rows.size(), failed_entries, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // the table is built at time zero, so its size is known after the first step.
  initial begin
    #1;
    #((rows.size() + preload_count + 20) * clock_period);
    $display("timeout: the table did not finish within the expected number of cycles");
    $display("Test failed");
    $finish;
  end

endmodule
